// File: all.f
design/icache_cfg_pkg.sv
design/icache_ctrl_pkg.sv
design/icache_ctrl.sv
design/icache_tag_lookup.sv
design/icache_data_array.sv
design/icache_repl.sv
design/icache_top.sv
sim/tb_icache_mem.sv
sim/tb_icache_top.sv

// File: design/icache_cfg_pkg.sv
// cache geometry, address field helpers, replacement LFSR constants and shared types
`default_nettype none

package icache_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////

  localparam int NUM_WAYS = 4;
  localparam int WAY_W    = 2;
  localparam int ADDR_W   = 32;
  // 16 byte lines
  localparam int OFFSET_W = 4;
  localparam int INDEX_W  = 4;
  localparam int NUM_SETS = 16;
  // whatever is left above index and offset
  localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WORD_W   = 32;
  localparam int LINE_W   = 128;

  // galois lfsr for random victim choice, x^8 + x^6 + x^5 + x^4 + 1
  localparam int               REPL_LFSR_W    = 8;
  localparam logic [REPL_LFSR_W-1:0] REPL_LFSR_TAPS = 8'hb8;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [WORD_W-1:0]   word_t;
  typedef logic [LINE_W-1:0]   line_t;
  typedef logic [WAY_W-1:0]    way_t;
  // one bit per way
  typedef logic [NUM_WAYS-1:0] way_oh_t;

  //////////////////////////////////////////////////////////////////////
  // address fields
  //////////////////////////////////////////////////////////////////////

  function automatic tag_t addr_tag(addr_t a);
    return a[ADDR_W-1:OFFSET_W+INDEX_W];
  endfunction

  function automatic index_t addr_index(addr_t a);
    return a[OFFSET_W+INDEX_W-1:OFFSET_W];
  endfunction

  // word within the line, bits 1..0 are ignored since fetches are word aligned
  function automatic logic [OFFSET_W-3:0] addr_word(addr_t a);
    return a[OFFSET_W-1:2];
  endfunction

endpackage

`default_nettype wire

// File: design/icache_ctrl.sv
// cache controller FSM, enable and flush handling, request address register
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl
  import icache_cfg_pkg::*;
  import icache_ctrl_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  req_i,
  input  wire addr_t addr_i,
  input  wire logic  en_i,
  input  wire logic  flush_i,
  input  wire logic  stall_i,
  input  wire logic  hit_i,
  input  wire logic  mem_ack_i,
  input  wire logic  mem_rtrn_vld_i,
  output logic       ready_o,
  output logic       valid_o,
  output logic       use_fill_o,
  output logic       lookup_o,
  output logic       fill_we_o,
  output logic       clear_we_o,
  output index_t     clear_index_o,
  output addr_t      req_addr_o,
  output logic       mem_req_o,
  output addr_t      mem_addr_o,
  output logic       miss_o,
  output logic       busy_o
);

  icache_state_e state_d, state_q;
  // cache enable, only set at the end of a sweep
  logic          cache_en_d, cache_en_q;
  // flush seen but not yet serviced
  logic          flush_d, flush_q;
  logic          flush_pend;
  // flush pending or enable just raised
  logic          need_flush;
  index_t        flush_cnt_d, flush_cnt_q;
  addr_t         req_addr_q;

  assign flush_pend = flush_q | flush_i;
  assign need_flush = flush_pend | (en_i & ~cache_en_q);

  // fetch accepted in this cycle starts the array read
  assign lookup_o      = ready_o & req_i;
  assign clear_index_o = flush_cnt_q;
  assign req_addr_o    = req_addr_q;
  // refills are always whole lines
  assign mem_addr_o    = {req_addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign busy_o        = (state_q != IDLE);

  //////////////////////////////////////////////////////////////////////
  // main FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    // dropping the enable is immediate
    cache_en_d  = cache_en_q & en_i;
    flush_d     = flush_pend;
    flush_cnt_d = '0;
    ready_o     = 1'b0;
    valid_o     = 1'b0;
    use_fill_o  = 1'b0;
    fill_we_o   = 1'b0;
    clear_we_o  = 1'b0;
    mem_req_o   = 1'b0;
    miss_o      = 1'b0;

    unique case (state_q)
      // clear valid bits of one set per cycle
      FLUSH: begin
        clear_we_o = 1'b1;
        if (flush_cnt_q == FLUSH_LAST) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          // whole cache is clean, enable may now take effect
          cache_en_d = en_i;
        end else begin
          flush_cnt_d = flush_cnt_q + 1'b1;
        end
      end
      // pending flushes win over new fetches
      IDLE: begin
        if (need_flush) begin
          state_d = FLUSH;
        end else if (!stall_i) begin
          ready_o = 1'b1;
          if (req_i) begin
            state_d = READ;
          end
        end
      end
      // compare result is ready here
      // a disabled cache reuses the miss path
      READ: begin
        if (hit_i && cache_en_q) begin
          valid_o = 1'b1;
          state_d = IDLE;
          // stream the next hit without a bubble
          if (!need_flush && !stall_i) begin
            ready_o = 1'b1;
            if (req_i) begin
              state_d = READ;
            end
          end
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            // uncached fetches are not counted as misses
            miss_o  = cache_en_q;
            state_d = MISS;
          end
        end
      end
      // wait for the single return beat
      MISS: begin
        use_fill_o = 1'b1;
        if (mem_rtrn_vld_i) begin
          valid_o   = 1'b1;
          fill_we_o = cache_en_q;
          state_d   = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  // address of the fetch in flight
  always_ff @(posedge clk_i) begin
    if (lookup_o) begin
      req_addr_q <= addr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  a_state_legal: assert property (
    @(posedge clk_i) disable iff (!rst_ni) state_q inside {FLUSH, IDLE, READ, MISS}
  ) else $error("icache ctrl reached an illegal state");

  // a refill write during the sweep would leave a stale line behind
  a_no_fill_in_flush: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (state_q == FLUSH) |-> !fill_we_o
  ) else $error("icache line written during flush sweep");

endmodule

`default_nettype wire

// File: design/icache_ctrl_pkg.sv
// controller state encoding and clear sweep timing
`default_nettype none

package icache_ctrl_pkg;

  // FLUSH   clear one set per cycle
  // IDLE    wait for a fetch
  // READ    tag compare of the accepted fetch
  // MISS    line refill outstanding
  typedef enum logic [1:0] {
    FLUSH = 2'd0,
    IDLE  = 2'd1,
    READ  = 2'd2,
    MISS  = 2'd3
  } icache_state_e;

  // last set touched by the sweep, one set per cycle from index 0
  localparam icache_cfg_pkg::index_t FLUSH_LAST =
    icache_cfg_pkg::index_t'(icache_cfg_pkg::NUM_SETS - 1);

endpackage

`default_nettype wire

// File: design/icache_data_array.sv
// per way line storage with registered read and fetch word select
`timescale 1ns/1ps
`default_nettype none

module icache_data_array
  import icache_cfg_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    lookup_i,
  input  wire addr_t   addr_i,
  input  wire addr_t   req_addr_i,
  input  wire logic    fill_we_i,
  input  wire way_oh_t victim_oh_i,
  input  wire line_t   fill_line_i,
  input  wire way_t    hit_way_i,
  input  wire logic    use_fill_i,
  output word_t        data_o
);

  line_t               line_q    [NUM_WAYS][NUM_SETS];
  // all ways of the looked up set
  line_t               rd_line_q [NUM_WAYS];
  logic [OFFSET_W-3:0] word_sel;
  word_t               hit_word;
  word_t               fill_word;

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      // refill goes to the victim way of the latched set
      if (fill_we_i && victim_oh_i[w]) begin
        line_q[w][addr_index(req_addr_i)] <= fill_line_i;
      end
      if (lookup_i) begin
        rd_line_q[w] <= line_q[w][addr_index(addr_i)];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // word select
  //////////////////////////////////////////////////////////////////////

  assign word_sel  = addr_word(req_addr_i);
  assign hit_word  = rd_line_q[hit_way_i][word_sel*WORD_W +: WORD_W];
  // during a refill the word comes straight from the return beat
  assign fill_word = fill_line_i[word_sel*WORD_W +: WORD_W];
  assign data_o    = use_fill_i ? fill_word : hit_word;

endmodule

`default_nettype wire

// File: design/icache_repl.sv
// victim way choice, invalid first with LFSR fallback
`timescale 1ns/1ps
`default_nettype none

module icache_repl
  import icache_cfg_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire way_oh_t valid_bits_i,
  input  wire logic    lookup_i,
  input  wire logic    fill_we_i,
  output way_oh_t      victim_oh_o
);

  logic [REPL_LFSR_W-1:0] lfsr_d, lfsr_q;
  // high in the compare cycle after a lookup
  logic                   cmp_q;
  logic                   all_valid;
  way_t                   inv_way;
  way_t                   rnd_way;
  way_oh_t                pick_oh;

  // lowest invalid way
  always_comb begin
    inv_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_bits_i[w]) begin
        inv_way = way_t'(w);
      end
    end
  end

  assign all_valid = &valid_bits_i;
  assign rnd_way   = lfsr_q[WAY_W-1:0];
  assign pick_oh   = way_oh_t'(1) << (all_valid ? rnd_way : inv_way);

  // right shifting galois step
  assign lfsr_d = lfsr_q[0] ? ((lfsr_q >> 1) ^ REPL_LFSR_TAPS) : (lfsr_q >> 1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmp_q       <= 1'b0;
      lfsr_q      <= {{(REPL_LFSR_W-1){1'b0}}, 1'b1};
      victim_oh_o <= '0;
    end else begin
      cmp_q <= lookup_i;
      // hold the choice for the refill
      if (cmp_q) begin
        victim_oh_o <= pick_oh;
      end
      // only a random eviction moves the sequence
      if (fill_we_i && all_valid) begin
        lfsr_q <= lfsr_d;
      end
    end
  end

  a_victim_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) fill_we_i |-> $onehot(victim_oh_o)
  ) else $error("icache refill without a single victim way");

endmodule

`default_nettype wire

// File: design/icache_tag_lookup.sv
// per way tag and valid storage, registered read and tag compare
`timescale 1ns/1ps
`default_nettype none

module icache_tag_lookup
  import icache_cfg_pkg::*;
  import icache_ctrl_pkg::*;
(
  input  wire logic    clk_i,
  input  wire logic    rst_ni,
  input  wire logic    lookup_i,
  input  wire addr_t   addr_i,
  input  wire addr_t   req_addr_i,
  input  wire logic    fill_we_i,
  input  wire way_oh_t victim_oh_i,
  input  wire logic    clear_we_i,
  input  wire index_t  clear_index_i,
  output logic         hit_o,
  output way_t         hit_way_o,
  output way_oh_t      valid_bits_o
);

  tag_t    tag_q   [NUM_WAYS][NUM_SETS];
  way_oh_t valid_q [NUM_SETS];
  // set read at lookup time
  tag_t    rd_tag_q [NUM_WAYS];
  way_oh_t rd_vld_q;
  way_oh_t hit_vec;
  logic    any_valid;

  // valid bits, cleared per set by the sweep
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '{default: '0};
      rd_vld_q <= '0;
    end else begin
      if (clear_we_i) begin
        valid_q[clear_index_i] <= '0;
      end else if (fill_we_i) begin
        valid_q[addr_index(req_addr_i)] <= valid_q[addr_index(req_addr_i)] | victim_oh_i;
      end
      if (lookup_i) begin
        rd_vld_q <= valid_q[addr_index(addr_i)];
      end
    end
  end

  // tag storage, victim way takes the latched tag
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (fill_we_i && victim_oh_i[w]) begin
        tag_q[w][addr_index(req_addr_i)] <= addr_tag(req_addr_i);
      end
      if (lookup_i) begin
        rd_tag_q[w] <= tag_q[w][addr_index(addr_i)];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    hit_vec   = '0;
    hit_way_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_vec[w] = rd_vld_q[w] && (rd_tag_q[w] == addr_tag(req_addr_i));
    end
    // lowest way wins
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_vec[w]) begin
        hit_way_o = way_t'(w);
      end
    end
  end

  assign hit_o        = |hit_vec;
  assign valid_bits_o = rd_vld_q;

  always_comb begin
    any_valid = 1'b0;
    for (int s = 0; s < NUM_SETS; s++) begin
      any_valid = any_valid | (|valid_q[s]);
    end
  end

  // compare cycle follows the lookup, a line may live in one way only
  a_hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) lookup_i |=> $onehot0(hit_vec)
  ) else $error("icache tag hit in more than one way");

  // the sweep must have covered every set
  a_sweep_clean: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
      (clear_we_i && clear_index_i == FLUSH_LAST) |=> !any_valid
  ) else $error("icache valid bit left set after flush sweep");

endmodule

`default_nettype wire

// File: design/icache_top.sv
// instruction cache top level, controller plus tag, data and replacement blocks
`timescale 1ns/1ps
`default_nettype none

module icache_top
  import icache_cfg_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  // fetch side
  input  wire logic  req_i,
  input  wire addr_t addr_i,
  output logic       ready_o,
  output logic       valid_o,
  output word_t      data_o,
  // control
  input  wire logic  en_i,
  input  wire logic  flush_i,
  input  wire logic  stall_i,
  output logic       miss_o,
  output logic       busy_o,
  // refill port
  output logic       mem_req_o,
  output addr_t      mem_addr_o,
  input  wire logic  mem_ack_i,
  input  wire logic  mem_rtrn_vld_i,
  input  wire line_t mem_rtrn_data_i
);

  // controller to arrays
  logic    lookup;
  logic    fill_we;
  logic    clear_we;
  index_t  clear_index;
  addr_t   req_addr;
  logic    use_fill;
  // arrays back to controller and replacement
  logic    hit;
  way_t    hit_way;
  way_oh_t valid_bits;
  way_oh_t victim_oh;

  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .addr_i         (addr_i),
    .en_i           (en_i),
    .flush_i        (flush_i),
    .stall_i        (stall_i),
    .hit_i          (hit),
    .mem_ack_i      (mem_ack_i),
    .mem_rtrn_vld_i (mem_rtrn_vld_i),
    .ready_o        (ready_o),
    .valid_o        (valid_o),
    .use_fill_o     (use_fill),
    .lookup_o       (lookup),
    .fill_we_o      (fill_we),
    .clear_we_o     (clear_we),
    .clear_index_o  (clear_index),
    .req_addr_o     (req_addr),
    .mem_req_o      (mem_req_o),
    .mem_addr_o     (mem_addr_o),
    .miss_o         (miss_o),
    .busy_o         (busy_o)
  );

  icache_tag_lookup u_tag (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lookup_i      (lookup),
    .addr_i        (addr_i),
    .req_addr_i    (req_addr),
    .fill_we_i     (fill_we),
    .victim_oh_i   (victim_oh),
    .clear_we_i    (clear_we),
    .clear_index_i (clear_index),
    .hit_o         (hit),
    .hit_way_o     (hit_way),
    .valid_bits_o  (valid_bits)
  );

  icache_data_array u_data (
    .clk_i       (clk_i),
    .lookup_i    (lookup),
    .addr_i      (addr_i),
    .req_addr_i  (req_addr),
    .fill_we_i   (fill_we),
    .victim_oh_i (victim_oh),
    .fill_line_i (mem_rtrn_data_i),
    .hit_way_i   (hit_way),
    .use_fill_i  (use_fill),
    .data_o      (data_o)
  );

  icache_repl u_repl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .valid_bits_i (valid_bits),
    .lookup_i     (lookup),
    .fill_we_i    (fill_we),
    .victim_oh_o  (victim_oh)
  );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the icache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f all.f \
  --top-module tb_icache_top \
  --Mdir obj_dir \
  -o sim_icache

./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
else
  exit 1
fi

// File: sim/tb_icache_mem.sv
// refill memory responder with programmable acknowledge delay and a single return beat
`timescale 1ns/1ps
`default_nettype none

module tb_icache_mem
  import icache_cfg_pkg::*;
(
  input  wire logic       clk_i,
  input  wire logic       rst_ni,
  input  wire logic       mem_req_i,
  // line contents for the requested address as supplied by the testbench
  input  wire line_t      line_i,
  input  wire logic [2:0] ack_dly_i,
  output logic            mem_ack_o,
  output logic            mem_rtrn_vld_o,
  output line_t           mem_rtrn_data_o
);

  logic [2:0] wait_cnt;
  line_t      line_q;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_ack_o       <= 1'b0;
      mem_rtrn_vld_o  <= 1'b0;
      mem_rtrn_data_o <= '0;
      wait_cnt        <= '0;
      line_q          <= '0;
    end else begin
      // return beat lasts one cycle
      mem_rtrn_vld_o <= 1'b0;
      if (mem_ack_o) begin
        // ack seen by the cache at this edge so the line returns next cycle
        mem_ack_o       <= 1'b0;
        mem_rtrn_vld_o  <= 1'b1;
        mem_rtrn_data_o <= line_q;
      end else if (mem_req_i && !mem_rtrn_vld_o) begin
        if (wait_cnt >= ack_dly_i) begin
          mem_ack_o <= 1'b1;
          line_q    <= line_i;
          wait_cnt  <= '0;
        end else begin
          wait_cnt <= wait_cnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_icache_top.sv
// clock, reset, random fetch stimulus, reference model, checks and watchdog of the icache testbench
`timescale 1ns/1ps
`default_nettype none

module tb_icache_top
  import icache_cfg_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int HIT_REQ    = 60;
  localparam int FLUSH_REQ  = 20;
  localparam int DIS_REQ    = 20;
  localparam int EN_REQ     = 20;
  localparam int STALL_REQ  = 30;
  // first fetch after reset plus every test loop
  localparam int TOTAL_REQ  = 1 + HIT_REQ + FLUSH_REQ + DIS_REQ + EN_REQ + STALL_REQ;
  // forty cycles per fetch plus three sweeps and the reset
  localparam int TIMEOUT_CYCLES = TOTAL_REQ * 40 + 3 * NUM_SETS + 10;
  localparam logic [31:0] SEED = 32'ha3d6;
  localparam tag_t TAG_POOL [6] = '{24'h000000, 24'h000001, 24'h0a5a5a,
                                   24'h123456, 24'hfedcba, 24'h7f0001};

  logic       clk_i;
  logic       rst_ni;
  logic       req_i;
  addr_t      addr_i;
  logic       ready_o;
  logic       valid_o;
  word_t      data_o;
  logic       en_i;
  logic       flush_i;
  logic       stall_i;
  logic       miss_o;
  logic       busy_o;
  logic       mem_req_o;
  addr_t      mem_addr_o;
  logic       mem_ack_i;
  logic       mem_rtrn_vld_i;
  line_t      mem_rtrn_data_i;
  line_t      mem_line;
  logic [2:0] ack_dly;

  logic [31:0] lfsr_state;
  int          cycle;
  int          err_cnt;
  int          err_start;
  int          tests_run;
  int          tests_failed;
  int          stall_len;
  // per test event counts observed and predicted
  int          mreq_seen;
  int          mreq_exp;
  int          miss_seen;
  int          miss_exp;
  logic        mreq_prev;
  addr_t       mreq_addr;
  // reference model state
  bit          model_en;
  bit          present [logic [27:0]];
  addr_t       exp_addr_q [$];
  int          exp_cyc_q [$];
  bit          exp_hit_q [$];

  icache_top dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .addr_i          (addr_i),
    .ready_o         (ready_o),
    .valid_o         (valid_o),
    .data_o          (data_o),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .stall_i         (stall_i),
    .miss_o          (miss_o),
    .busy_o          (busy_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i)
  );

  tb_icache_mem u_mem (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .mem_req_i       (mem_req_o),
    .line_i          (mem_line),
    .ack_dly_i       (ack_dly),
    .mem_ack_o       (mem_ack_i),
    .mem_rtrn_vld_o  (mem_rtrn_vld_i),
    .mem_rtrn_data_o (mem_rtrn_data_i)
  );

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  // word k of a line is its own word address xor a fixed pattern
  function automatic line_t line_of(input addr_t a);
    line_t l;
    for (int k = 0; k < 4; k++) begin
      l[k*32 +: 32] = {a[31:4], 2'(k), 2'b00} ^ 32'h5a5a_0f0f;
    end
    return l;
  endfunction

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  assign mem_line = line_of(mem_addr_o);

  task automatic report_fail(input string msg);
    $display("Fail at %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic check_result;
    addr_t a;
    int    c;
    bit    h;
    line_t l;
    word_t w;
    if (exp_addr_q.size() == 0) begin
      report_fail("valid_o without an outstanding request");
    end else begin
      a = exp_addr_q.pop_front();
      c = exp_cyc_q.pop_front();
      h = exp_hit_q.pop_front();
      l = line_of(a);
      w = l[a[3:2]*32 +: 32];
      if (data_o !== w) begin
        report_fail($sformatf("data %h for address %h, expected %h", data_o, a, w));
      end
      if (h && cycle != c) begin
        report_fail($sformatf("hit on %h not returned one cycle after acceptance", a));
      end
      if (!h && model_en) begin
        present[a[31:4]] = 1'b1;
      end
    end
  endtask

  task automatic record_accept;
    bit h;
    h = model_en && present.exists(addr_i[31:4]);
    exp_addr_q.push_back(addr_i);
    exp_cyc_q.push_back(cycle + 1);
    exp_hit_q.push_back(h);
    if (!h) begin
      mreq_exp++;
      if (model_en) begin
        miss_exp++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // clock, cycle count, monitor
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
  end

  // outputs settle well before the falling edge
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // result first so that a streamed hit sees the line marked present
      if (valid_o) begin
        check_result();
      end
      if (mem_req_o) begin
        if (!mreq_prev) begin
          mreq_seen++;
        end else if (mem_addr_o !== mreq_addr) begin
          report_fail($sformatf("refill address changed from %h to %h while mem_req_o held",
                                mreq_addr, mem_addr_o));
        end
        if (mem_addr_o[OFFSET_W-1:0] != '0) begin
          report_fail($sformatf("refill address %h not line aligned", mem_addr_o));
        end
      end
      mreq_prev = mem_req_o;
      mreq_addr = mem_addr_o;
      if (miss_o) begin
        miss_seen++;
      end
      if (stall_i && ready_o) begin
        report_fail("ready_o high while stall_i is high");
      end
      if (req_i && ready_o) begin
        record_accept();
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // one fetch from the first nslots tags of the pool that returns at the accepting edge
  task automatic fetch(input int nslots);
    logic [31:0] slot;
    logic [31:0] set;
    logic [31:0] wrd;
    int          guard;
    slot = rnd(3) % nslots;
    set  = rnd(4);
    wrd  = rnd(2);
    ack_dly <= 3'(rnd(3));
    req_i   <= 1'b1;
    addr_i  <= {TAG_POOL[slot], set[3:0], wrd[1:0], 2'b00};
    guard = 0;
    @(negedge clk_i);
    while (!ready_o && guard < 100) begin
      @(negedge clk_i);
      guard++;
    end
    @(posedge clk_i);
    req_i <= 1'b0;
    if (guard >= 100) begin
      $display("fetch was never accepted by the cache");
      err_cnt++;
    end
  endtask

  // gap of 0 to 3 cycles where zero keeps hits streaming
  task automatic gap;
    logic [31:0] n;
    n = rnd(2);
    repeat (n) @(posedge clk_i);
  endtask

  // busy_o must cover exactly one set per cycle with no fetch or refill
  task automatic check_sweep;
    int n;
    int guard;
    n = 0;
    guard = 0;
    @(negedge clk_i);
    while (!busy_o && guard < 20) begin
      @(negedge clk_i);
      guard++;
    end
    while (busy_o && n < 100) begin
      if (ready_o || mem_req_o) begin
        report_fail("ready_o or mem_req_o high during the clear sweep");
      end
      n++;
      @(negedge clk_i);
    end
    if (n != NUM_SETS) begin
      report_fail($sformatf("sweep took %0d cycles, expected %0d", n, NUM_SETS));
    end
    @(posedge clk_i);
  endtask

  task automatic drain;
    int guard;
    guard = 0;
    while (exp_addr_q.size() != 0 && guard < 200) begin
      @(negedge clk_i);
      guard++;
    end
    if (exp_addr_q.size() != 0) begin
      $display("outstanding fetches never returned a result");
      err_cnt++;
    end
    @(posedge clk_i);
  endtask

  task automatic begin_test;
    err_start = err_cnt;
    mreq_seen = 0;
    mreq_exp  = 0;
    miss_seen = 0;
    miss_exp  = 0;
  endtask

  task automatic end_test(input string name);
    drain();
    if (mreq_seen != mreq_exp) begin
      report_fail($sformatf("%0d memory requests, expected %0d", mreq_seen, mreq_exp));
    end
    if (miss_seen != miss_exp) begin
      report_fail($sformatf("%0d miss pulses, expected %0d", miss_seen, miss_exp));
    end
    tests_run++;
    if (err_cnt == err_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the run did not complete in time");
    $display("Simulation finished: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    lfsr_state   = SEED;
    cycle        = 0;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;
    stall_len    = 0;
    mreq_prev    = 1'b0;
    mreq_addr    = '0;
    model_en     = 1'b1;
    rst_ni       = 1'b0;
    req_i        = 1'b0;
    addr_i       = '0;
    en_i         = 1'b1;
    flush_i      = 1'b0;
    stall_i      = 1'b0;
    ack_dly      = '0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    begin_test();
    check_sweep();
    fetch(4);
    end_test("reset sweep and first fetch");

    // at most 4 tags per set so nothing gets evicted
    begin_test();
    repeat (HIT_REQ) begin
      fetch(4);
      gap();
    end
    end_test("hits and misses");

    begin_test();
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    present.delete();
    check_sweep();
    repeat (FLUSH_REQ) begin
      fetch(4);
      gap();
    end
    end_test("flush");

    // every tag of the pool and none may be stored
    begin_test();
    en_i <= 1'b0;
    model_en = 1'b0;
    repeat (DIS_REQ) begin
      fetch(6);
      gap();
    end
    end_test("disabled");

    begin_test();
    en_i <= 1'b1;
    check_sweep();
    present.delete();
    model_en = 1'b1;
    repeat (EN_REQ) begin
      fetch(4);
      gap();
    end
    end_test("enable again");

    // stall while a new fetch waits and the previous one may still be in flight
    begin_test();
    repeat (STALL_REQ) begin
      if (rnd(1) != 0) begin
        stall_i <= 1'b1;
        stall_len = rnd(3);
        fork
          fetch(4);
          begin
            repeat (stall_len) @(posedge clk_i);
            stall_i <= 1'b0;
          end
        join
      end else begin
        fetch(4);
      end
      gap();
    end
    end_test("stall");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
